/* compile.f */
src/cpuTypesPkg.sv
src/ctrlWordPkg.sv
src/opcodeDecoder.sv
src/ctrlRom.sv
src/intArbiter.sv
src/tSequencer.sv
src/cpuControl.sv
dv/cpuControl_props.sv
dv/cpuControl_tb.sv

/* dv/cpuControl_props.sv */
`timescale 1ns/1ns

module cpuControl_props (
    input logic                  loadIR,
    input logic                  rst,
    input logic                  rdy,
    input logic                  intReq,
    input logic                  intAck,
    input cpuTypesPkg::intKindT  intKind,
    input ctrlWordPkg::ctrlWordT ctrlWord,
    input logic                  rstHandled,
    input logic                  nmiHandled,
    input logic                  irqHandled
);

    int unsigned propFails = 0;  // failed assertion count

    task automatic countFailure(input string what);
        propFails++;
        $error("%s", what);
    endtask

    // four-phase req/ack between arbiter and sequencer
    ackNeedsReq: assert property (@(posedge loadIR) disable iff (rst) $rose(intAck) |-> intReq)
        else countFailure("intAck rose with no intReq pending");
    reqDrops: assert property (@(posedge loadIR) disable iff (rst) intReq && intAck |=> !intReq)
        else countFailure("intReq still high a cycle after intAck");
    ackDrops: assert property (@(posedge loadIR) disable iff (rst) intAck && !intReq |=> !intAck)
        else countFailure("intAck still high a cycle after intReq fell");
    reqAfterAck: assert property (@(posedge loadIR) disable iff (rst)
        $rose(intReq) |-> !$past(intAck))
        else countFailure("new intReq raised while intAck was high");
    kindStable: assert property (@(posedge loadIR) disable iff (rst)
        intReq && $past(intReq) |-> $stable(intKind))
        else countFailure("intKind changed while intReq was high");

    // stalled cycles issue nothing
    idleWhenStalled: assert property (@(posedge loadIR) disable iff (rst)
        !rdy |-> ctrlWord == ctrlWordPkg::ctrlIdle)
        else countFailure("ctrlWord not idle while rdy was low");

    pulseOnce: assert property (@(posedge loadIR) disable iff (rst)
        (rstHandled || nmiHandled || irqHandled) |=> !(rstHandled || nmiHandled || irqHandled))
        else countFailure("handled output high for more than one cycle");

endmodule

bind cpuControl cpuControl_props u_cpuControlProps (
    .loadIR(loadIR), .rst(rst), .rdy(rdy), .intReq(intReq), .intAck(intAck),
    .intKind(intKind), .ctrlWord(ctrlWord), .rstHandled(rstHandled),
    .nmiHandled(nmiHandled), .irqHandled(irqHandled)
);

/* dv/cpuControl_tb.sv */
`timescale 1ns/1ns

module cpuControl_tb;

    localparam int brkLength = 7;
    localparam int maxCycles = 4000;  // about five times the cycles all tests need
    localparam logic [7:0] brkWrites = 8'b0011_1000;  // stack pushes in T3 to T5
    localparam logic [7:0] brkVecs = 8'b1100_0000;    // vector reads in T6 and T7

    logic                  loadIR;
    logic                  rst;
    logic                  rdy;
    logic                  nmi;
    logic                  irq;
    cpuTypesPkg::opcodeT   opcodeIn;
    cpuTypesPkg::statusT   statusReg;
    ctrlWordPkg::ctrlWordT ctrlWord;
    logic                  sync;
    cpuTypesPkg::tStateT   tState;
    logic                  rstHandled;
    logic                  nmiHandled;
    logic                  irqHandled;

    integer seed;
    int     checks = 0;
    int     errors = 0;
    int     errMark = 0;   // errors at the start of the current test
    int     cycles = 0;
    int     rstCount = 0;
    int     nmiCount = 0;
    int     irqCount = 0;
    logic   stallOn = 1'b0;  // random rdy low cycles when set

    cpuControl #(.brkLength(brkLength)) u_cpuControl (.*);

    initial begin
        loadIR = 1'b0;
        forever #4 loadIR = ~loadIR;
    end

    // handled pulse counts and the run limit
    always @(posedge loadIR) begin
        cycles++;
        if (!rst && rstHandled) rstCount++;
        if (!rst && nmiHandled) nmiCount++;
        if (!rst && irqHandled) irqCount++;
        if (cycles >= maxCycles) begin
            $display("timeout: run still going after %0d cycles", maxCycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // expected cycles from T1 to the next sync
    function automatic int lengthOf(input cpuTypesPkg::opcodeT op, input cpuTypesPkg::statusT st);
        logic flag;
        case (op[7:6])
            2'd0:    flag = st[7];  // N
            2'd1:    flag = st[6];  // V
            2'd2:    flag = st[0];  // C
            default: flag = st[1];  // Z
        endcase
        if (op == 8'h00) return brkLength;
        if (op[3:0] == 4'h0 && op[4]) return (flag == op[5]) ? 3 : 2;
        if (op[3:0] == 4'h6 || op[3:0] == 4'hE) return 5;
        return 2;
    endfunction

    // one bit per T state that must show memWrite
    function automatic logic [7:0] writesOf(input cpuTypesPkg::opcodeT op);
        if (op == 8'h00) return brkWrites;
        if (op[3:0] == 4'h6 || op[3:0] == 4'hE) return 8'b0011_0000;  // T4, T5
        return 8'h00;
    endfunction

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("error at %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic reportTest(input string name);
        $display("test %s finished with %0d errors", name, errors - errMark);
        errMark = errors;
    endtask

    // step until sync rises on an advancing edge and count only rdy high cycles
    task automatic runToSync(output int len, output logic [7:0] wrMask,
                             output logic [7:0] vfMask);
        logic                wasRdy;
        logic                prevSync;
        cpuTypesPkg::tStateT prevT;
        len = 0;
        wrMask = 8'h00;
        vfMask = 8'h00;
        do begin
            rdy = !stallOn || ($random(seed) % 4 != 0);
            wasRdy = rdy;
            prevT = tState;
            prevSync = sync;
            @(negedge loadIR);  // control word has settled by mid cycle
            if (wasRdy && ctrlWord.memWrite) wrMask[tState] = 1'b1;
            if (wasRdy && ctrlWord.vecFetch) vfMask[tState] = 1'b1;
            @(posedge loadIR);
            #1;
            if (wasRdy) len++;
            else check(tState == prevT && sync == prevSync,
                       "tState or sync moved while rdy was low");
        end while (!(wasRdy && sync));
    endtask

    // called in a sync cycle with the opcode going on the bus for T1
    task automatic runInstr(input cpuTypesPkg::opcodeT op, input logic intTaken);
        int         len;
        int         expLen;
        logic [7:0] wrMask;
        logic [7:0] expMask;
        logic [7:0] vfMask;
        logic [7:0] expVf;
        opcodeIn = op;
        expLen = lengthOf(op, statusReg) + (intTaken ? brkLength : 0);
        expMask = writesOf(op) | (intTaken ? brkWrites : 8'h00);
        expVf = (op == 8'h00 || intTaken) ? brkVecs : 8'h00;
        runToSync(len, wrMask, vfMask);
        check(len == expLen, $sformatf("opcode %h took %0d cycles, expected %0d", op, len, expLen));
        check(wrMask == expMask,
              $sformatf("opcode %h wrote in states %b, expected %b", op, wrMask, expMask));
        check(vfMask == expVf,
              $sformatf("opcode %h fetched vectors in states %b, expected %b", op, vfMask, expVf));
    endtask

    initial begin
        int         len;
        int         i;
        int         k;
        logic [7:0] wrMask;
        logic [7:0] vfMask;
        seed = 32'h068c_25d3;
        rst = 1'b1;
        rdy = 1'b1;
        nmi = 1'b0;
        irq = 1'b0;
        opcodeIn = 8'hEA;
        statusReg = 8'h00;
        repeat (8) @(posedge loadIR);
        #1;
        rst = 1'b0;

        runToSync(len, wrMask, vfMask);  // reset runs as a break sequence
        check(len == brkLength, $sformatf("reset sequence took %0d cycles", len));
        check(vfMask == brkVecs, $sformatf("reset fetched vectors in states %b", vfMask));
        runInstr(8'hEA, 1'b0);
        check(rstCount == 1, $sformatf("rstHandled pulsed %0d times", rstCount));
        reportTest("reset");

        for (i = 0; i < 150; i++) begin
            statusReg = 8'($random(seed));
            runInstr(8'($random(seed)), 1'b0);
        end
        runInstr(8'h00, 1'b0);  // software BRK
        runInstr(8'hFE, 1'b0);
        reportTest("lengths");

        for (k = 0; k < 8; k++) begin  // every branch opcode with flags clear, set and random
            statusReg = 8'h00;
            runInstr({k[2:0], 5'h10}, 1'b0);
            statusReg = 8'hFF;
            runInstr({k[2:0], 5'h10}, 1'b0);
            statusReg = 8'($random(seed));
            runInstr({k[2:0], 5'h10}, 1'b0);
        end
        reportTest("branches");

        statusReg = 8'h00;  // I clear
        nmi = 1'b1;
        irq = 1'b1;
        runInstr(8'h0E, 1'b1);  // nmi outranks irq at the end of the RMW
        nmi = 1'b0;
        runInstr(8'hEA, 1'b0);  // irq request waits for intAck to clear
        check(nmiCount == 1 && irqCount == 0, "nmi was not served alone first");
        runInstr(8'hEA, 1'b1);
        statusReg = 8'h04;      // I set while irq stays high
        runInstr(8'hEA, 1'b0);
        check(irqCount == 1, $sformatf("irqHandled pulsed %0d times", irqCount));
        for (i = 0; i < 6; i++) runInstr(8'h2E, 1'b0);
        check(irqCount == 1 && nmiCount == 1, "masked irq was served");
        irq = 1'b0;
        statusReg = 8'h00;
        reportTest("interrupts");

        stallOn = 1'b1;
        for (i = 0; i < 40; i++) begin
            statusReg = 8'($random(seed));
            runInstr(8'($random(seed)), 1'b0);
        end
        stallOn = 1'b0;
        rdy = 1'b1;
        reportTest("rdy stall");

        for (i = 0; i < 16; i++) begin
            runInstr({i[3:0], 4'h6}, 1'b0);
            runInstr({i[3:0], 4'hE}, 1'b0);
            runInstr({i[3:0], 4'hA}, 1'b0);  // normal opcode without writes
        end
        reportTest("rmw writes");

        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, u_cpuControl.u_cpuControlProps.propFails);
        if (errors == 0 && u_cpuControl.u_cpuControlProps.propFails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# builds the cpuControl testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module cpuControl_tb -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VcpuControl_tb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qF '*** TEST FAILED ***' sim.log; then
    exit 1
fi
exit 0

/* src/cpuControl.sv */
`timescale 1ns/1ns

module cpuControl #(
    parameter int brkLength = 7  // break sequence cycles
) (
    input  logic                  loadIR,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  nmi,
    input  logic                  irq,
    input  cpuTypesPkg::opcodeT   opcodeIn,
    input  cpuTypesPkg::statusT   statusReg,
    output ctrlWordPkg::ctrlWordT ctrlWord,
    output logic                  sync,
    output cpuTypesPkg::tStateT   tState,
    output logic                  rstHandled,
    output logic                  nmiHandled,
    output logic                  irqHandled
);

    cpuTypesPkg::opcodeT    curOpcode;
    cpuTypesPkg::instClassT instClass;
    cpuTypesPkg::instClassT romClass;
    cpuTypesPkg::intKindT   intKind;
    ctrlWordPkg::ctrlWordT  romWord;  // before rdy gating
    logic [2:0]             instLength;
    logic                   intReq;
    logic                   intAck;

    opcodeDecoder #(.brkLength(brkLength)) u_opcodeDecoder (
        .opcode      (curOpcode),
        .status      (statusReg),
        .instLength  (instLength),
        .instClass   (instClass),
        .branchTaken ()  // already folded into instLength
    );

    ctrlRom u_ctrlRom (
        .romClass (romClass),
        .intKind  (intKind),
        .tState   (tState),
        .ctrlWord (romWord)
    );

    intArbiter u_intArbiter (
        .loadIR     (loadIR),
        .rst        (rst),
        .nmi        (nmi),
        .irq        (irq),
        .status     (statusReg),
        .intAck     (intAck),
        .intReq     (intReq),
        .intKind    (intKind),
        .rstHandled (rstHandled),
        .nmiHandled (nmiHandled),
        .irqHandled (irqHandled)
    );

    tSequencer #(.brkLength(brkLength)) u_tSequencer (
        .loadIR     (loadIR),
        .rst        (rst),
        .rdy        (rdy),
        .opcodeIn   (opcodeIn),
        .intReq     (intReq),
        .intKind    (intKind),
        .instClass  (instClass),
        .instLength (instLength),
        .ctrlIn     (romWord),
        .curOpcode  (curOpcode),
        .romClass   (romClass),
        .tState     (tState),
        .sync       (sync),
        .intAck     (intAck),
        .ctrlWord   (ctrlWord)
    );

endmodule

/* src/cpuTypesPkg.sv */
package cpuTypesPkg;

    typedef logic [7:0] opcodeT;  // raw instruction byte
    typedef logic [7:0] statusT;  // NV--DIZC layout

    // flag positions inside statusT
    localparam int flagN = 7;
    localparam int flagV = 6;
    localparam int flagI = 2;  // irq mask
    localparam int flagZ = 1;
    localparam int flagC = 0;

    // timing state, T1 is the opcode fetch cycle
    typedef enum logic [2:0] {
        T1 = 3'd1,
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4,
        T5 = 3'd5,
        T6 = 3'd6,
        T7 = 3'd7
    } tStateT;

    typedef enum logic [1:0] {
        clsNorm,    // fixed two cycle
        clsRmw,     // read, dummy write, write
        clsBranch,  // length depends on flags
        clsBrk      // break / interrupt sequence
    } instClassT;

    typedef enum logic [1:0] {intNone, intRst, intNmi, intIrq} intKindT;

    typedef enum logic [1:0] {seqFetch, seqExec, seqBrk} seqStateT;

endpackage

/* src/ctrlRom.sv */
`timescale 1ns/1ns

module ctrlRom (
    input  cpuTypesPkg::instClassT romClass,
    input  cpuTypesPkg::intKindT   intKind,
    input  cpuTypesPkg::tStateT    tState,
    output ctrlWordPkg::ctrlWordT  ctrlWord
);

    ctrlWordPkg::aluOpT vecSel;

    // vector chosen by the kind being served
    always_comb begin
        case (intKind)
            cpuTypesPkg::intRst: vecSel = ctrlWordPkg::vecRst;
            cpuTypesPkg::intNmi: vecSel = ctrlWordPkg::vecNmi;
            default:             vecSel = ctrlWordPkg::vecIrq;  // irq and BRK
        endcase
    end

    always_comb begin
        ctrlWord = ctrlWordPkg::ctrlIdle;
        if (tState == cpuTypesPkg::T1) begin
            ctrlWord.pcInc   = 1'b1;  // opcode fetch, same for every class
            ctrlWord.addrSel = ctrlWordPkg::addrPc;
            ctrlWord.memRead = 1'b1;
        end else begin
            case (romClass)
                cpuTypesPkg::clsNorm: begin
                    ctrlWord.pcInc    = 1'b1;  // operand fetch and execute
                    ctrlWord.memRead  = 1'b1;
                    ctrlWord.aluOp    = ctrlWordPkg::aluAdd;
                    ctrlWord.regWrite = 1'b1;
                    ctrlWord.flagLoad = 1'b1;
                end
                cpuTypesPkg::clsRmw: begin
                    ctrlWord.addrSel = ctrlWordPkg::addrOper;
                    case (tState)
                        cpuTypesPkg::T2: begin
                            ctrlWord.pcInc   = 1'b1;
                            ctrlWord.addrSel = ctrlWordPkg::addrPc;  // address byte
                            ctrlWord.memRead = 1'b1;
                        end
                        cpuTypesPkg::T3: ctrlWord.memRead = 1'b1;   // read old value
                        cpuTypesPkg::T4: ctrlWord.memWrite = 1'b1;  // dummy write back
                        default: begin
                            ctrlWord.memWrite = 1'b1;  // modified value
                            ctrlWord.aluOp    = ctrlWordPkg::aluInc;
                            ctrlWord.flagLoad = 1'b1;
                        end
                    endcase
                end
                cpuTypesPkg::clsBranch: begin
                    if (tState == cpuTypesPkg::T2) begin
                        ctrlWord.pcInc   = 1'b1;  // offset byte
                        ctrlWord.memRead = 1'b1;
                    end else begin
                        ctrlWord.aluOp = ctrlWordPkg::aluAdd;  // pc + offset
                    end
                end
                default: begin
                    case (tState)
                        cpuTypesPkg::T2: ctrlWord.memRead = 1'b1;  // discarded read
                        cpuTypesPkg::T3, cpuTypesPkg::T4, cpuTypesPkg::T5: begin
                            ctrlWord.addrSel   = ctrlWordPkg::addrStack;
                            ctrlWord.memWrite  = 1'b1;  // pch, pcl, then P
                            ctrlWord.stackPush = 1'b1;
                        end
                        default: begin
                            ctrlWord.addrSel  = ctrlWordPkg::addrVec;
                            ctrlWord.memRead  = 1'b1;
                            ctrlWord.vecFetch = 1'b1;
                            ctrlWord.aluOp    = vecSel;
                            ctrlWord.setI     = (tState == cpuTypesPkg::T6);
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

/* src/ctrlWordPkg.sv */
package ctrlWordPkg;

    typedef logic [2:0] aluOpT;
    typedef logic [1:0] addrSelT;

    // address bus sources
    localparam addrSelT addrPc    = 2'd0;
    localparam addrSelT addrOper  = 2'd1;  // operand / effective address
    localparam addrSelT addrStack = 2'd2;
    localparam addrSelT addrVec   = 2'd3;

    localparam aluOpT aluNop = 3'd0;
    localparam aluOpT aluAdd = 3'd1;
    localparam aluOpT aluInc = 3'd2;
    localparam aluOpT aluDec = 3'd3;

    // during vecFetch the aluOp field carries the vector index instead
    localparam aluOpT vecIrq = 3'd1;  // shared with software BRK
    localparam aluOpT vecRst = 3'd2;
    localparam aluOpT vecNmi = 3'd3;

    typedef struct packed {
        logic    pcInc;
        addrSelT addrSel;
        aluOpT   aluOp;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    stackPush;  // also decrements SP
        logic    flagLoad;
        logic    vecFetch;
        logic    setI;
        logic [2:0] spare;
    } ctrlWordT;  // 16 bits

    localparam ctrlWordT ctrlIdle = '0;

endpackage

/* src/intArbiter.sv */
`timescale 1ns/1ns

module intArbiter (
    input  logic                 loadIR,
    input  logic                 rst,
    input  logic                 nmi,
    input  logic                 irq,
    input  cpuTypesPkg::statusT  status,
    input  logic                 intAck,
    output logic                 intReq,
    output cpuTypesPkg::intKindT intKind,
    output logic                 rstHandled,
    output logic                 nmiHandled,
    output logic                 irqHandled
);

    typedef enum logic {arbIdle, arbReq} arbStateT;

    arbStateT             state;
    logic                 nmiQ;     // nmi from last cycle, for edge detect
    logic                 nmiPend;  // edge seen, not yet served
    logic                 nmiEdge;
    logic                 irqLive;
    cpuTypesPkg::intKindT nextKind;

    assign nmiEdge = nmi & ~nmiQ;
    assign irqLive = irq & ~status[cpuTypesPkg::flagI];  // masked by I
    assign intReq  = (state == arbReq);

    // rst is taken by the reset branch below, so nmi then irq here
    always_comb begin
        if (nmiPend || nmiEdge) nextKind = cpuTypesPkg::intNmi;
        else if (irqLive)       nextKind = cpuTypesPkg::intIrq;
        else                    nextKind = cpuTypesPkg::intNone;
    end

    always_ff @(posedge loadIR) begin
        rstHandled <= 1'b0;  // pulses, one cycle only
        nmiHandled <= 1'b0;
        irqHandled <= 1'b0;
        if (rst) begin
            state   <= arbReq;  // reset sequence is requested from the start
            intKind <= cpuTypesPkg::intRst;
            nmiQ    <= 1'b0;
            nmiPend <= 1'b0;
        end else begin
            nmiQ <= nmi;
            if (nmiEdge) nmiPend <= 1'b1;
            case (state)
                arbIdle: begin
                    // wait for the previous ack to clear first
                    if (!intAck && nextKind != cpuTypesPkg::intNone) begin
                        state   <= arbReq;
                        intKind <= nextKind;
                    end
                end
                default: begin
                    if (intAck) begin
                        state   <= arbIdle;
                        intKind <= cpuTypesPkg::intNone;
                        case (intKind)
                            cpuTypesPkg::intRst: rstHandled <= 1'b1;
                            cpuTypesPkg::intNmi: begin
                                nmiHandled <= 1'b1;
                                nmiPend    <= nmiEdge;  // keep an edge arriving now
                            end
                            cpuTypesPkg::intIrq: irqHandled <= 1'b1;
                            default: ;
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

/* src/opcodeDecoder.sv */
`timescale 1ns/1ns

module opcodeDecoder #(
    parameter int brkLength = 7
) (
    input  cpuTypesPkg::opcodeT    opcode,
    input  cpuTypesPkg::statusT    status,
    output logic [2:0]             instLength,  // cycles including T1
    output cpuTypesPkg::instClassT instClass,
    output logic                   branchTaken
);

    logic flagSel;  // flag picked by opcode[7:6]

    // class rule, first match wins
    always_comb begin
        if (opcode == 8'h00) begin
            instClass = cpuTypesPkg::clsBrk;
        end else if (opcode[3:0] == 4'h0 && opcode[4]) begin
            instClass = cpuTypesPkg::clsBranch;  // x0 with odd high nibble
        end else if (opcode[3:0] == 4'h6 || opcode[3:0] == 4'hE) begin
            instClass = cpuTypesPkg::clsRmw;
        end else begin
            instClass = cpuTypesPkg::clsNorm;
        end
    end

    always_comb begin
        case (opcode[7:6])
            2'd0:    flagSel = status[cpuTypesPkg::flagN];
            2'd1:    flagSel = status[cpuTypesPkg::flagV];
            2'd2:    flagSel = status[cpuTypesPkg::flagC];
            default: flagSel = status[cpuTypesPkg::flagZ];
        endcase
    end

    // bit 5 is the value the flag must hold for the branch to go
    assign branchTaken = (instClass == cpuTypesPkg::clsBranch) && (flagSel == opcode[5]);

    always_comb begin
        case (instClass)
            cpuTypesPkg::clsRmw:    instLength = 3'd5;
            cpuTypesPkg::clsBranch: instLength = branchTaken ? 3'd3 : 3'd2;
            cpuTypesPkg::clsBrk:    instLength = 3'(brkLength);
            default:                instLength = 3'd2;
        endcase
    end

endmodule

/* src/tSequencer.sv */
`timescale 1ns/1ns

module tSequencer #(
    parameter int brkLength = 7
) (
    input  logic                   loadIR,
    input  logic                   rst,
    input  logic                   rdy,
    input  cpuTypesPkg::opcodeT    opcodeIn,
    input  logic                   intReq,
    input  cpuTypesPkg::intKindT   intKind,
    input  cpuTypesPkg::instClassT instClass,
    input  logic [2:0]             instLength,
    input  ctrlWordPkg::ctrlWordT  ctrlIn,
    output cpuTypesPkg::opcodeT    curOpcode,
    output cpuTypesPkg::instClassT romClass,
    output cpuTypesPkg::tStateT    tState,
    output logic                   sync,
    output logic                   intAck,
    output ctrlWordPkg::ctrlWordT  ctrlWord
);

    cpuTypesPkg::seqStateT state;
    cpuTypesPkg::opcodeT   opReg;    // opcode of the running instruction
    cpuTypesPkg::intKindT  svcKind;  // intNone for a software BRK
    cpuTypesPkg::tStateT   tNext;
    logic                  rstIdle;  // dummy first cycle out of reset
    logic                  lastExec;
    logic                  lastBrk;
    logic                  takeInt;

    // in T1 the decoder looks straight at the bus, like a predecode
    assign curOpcode = (state == cpuTypesPkg::seqFetch) ? opcodeIn : opReg;
    assign sync      = (state == cpuTypesPkg::seqFetch);
    assign tNext     = cpuTypesPkg::tStateT'(tState + 3'd1);
    assign lastExec  = (tState == instLength);
    assign lastBrk   = (tState == 3'(brkLength));
    assign takeInt   = intReq && !intAck && (intKind != cpuTypesPkg::intNone);

    always_comb begin
        case (state)
            cpuTypesPkg::seqExec: romClass = instClass;
            cpuTypesPkg::seqBrk:  romClass = cpuTypesPkg::clsBrk;
            default:              romClass = cpuTypesPkg::clsNorm;  // T1 is common
        endcase
    end

    assign ctrlWord = (rdy && !rstIdle) ? ctrlIn : ctrlWordPkg::ctrlIdle;

    always_ff @(posedge loadIR) begin
        if (rst) begin
            state   <= cpuTypesPkg::seqBrk;  // reset runs as a break sequence
            tState  <= cpuTypesPkg::T1;
            svcKind <= cpuTypesPkg::intRst;
            intAck  <= 1'b0;
            rstIdle <= 1'b1;
        end else begin
            rstIdle <= 1'b0;
            if (intAck && !intReq) intAck <= 1'b0;  // close the four-phase loop
            if (rdy) begin  // rdy low freezes everything below
                case (state)
                    cpuTypesPkg::seqFetch: begin
                        opReg  <= opcodeIn;
                        tState <= cpuTypesPkg::T2;
                        if (instClass == cpuTypesPkg::clsBrk) begin
                            state   <= cpuTypesPkg::seqBrk;
                            svcKind <= cpuTypesPkg::intNone;
                        end else begin
                            state <= cpuTypesPkg::seqExec;
                        end
                    end
                    cpuTypesPkg::seqExec: begin
                        if (lastExec) begin
                            tState <= cpuTypesPkg::T1;
                            if (takeInt) begin  // only point where irqs are seen
                                state   <= cpuTypesPkg::seqBrk;
                                svcKind <= intKind;
                            end else begin
                                state <= cpuTypesPkg::seqFetch;
                            end
                        end else begin
                            tState <= tNext;
                        end
                    end
                    cpuTypesPkg::seqBrk: begin
                        if (lastBrk) begin
                            state  <= cpuTypesPkg::seqFetch;
                            tState <= cpuTypesPkg::T1;
                            if (svcKind != cpuTypesPkg::intNone) intAck <= 1'b1;
                        end else begin
                            tState <= tNext;
                        end
                    end
                    default: begin
                        state  <= cpuTypesPkg::seqFetch;
                        tState <= cpuTypesPkg::T1;
                    end
                endcase
            end
        end
    end

endmodule
